//--- rtl/glue_pkg.sv
package glue_pkg;

  // ========================================
  // board widths
  // ========================================
  localparam int unsigned num_keys    = 4;   // push keys, active low
  localparam int unsigned num_sw      = 10;  // slide switches
  localparam int unsigned num_led_pio = 9;   // leds owned by the processor
  localparam int unsigned num_ledr    = 10;  // led_pio plus heartbeat

  // trace event word, zero padded on top
  localparam int unsigned stm_width     = 28;
  localparam int unsigned stm_pad_width = stm_width - num_sw - num_led_pio - num_keys;

  // ========================================
  // timing defaults, 50 MHz clock
  // ========================================
  localparam int unsigned debounce_cycles_default   = 50000;     // 1 ms
  localparam int unsigned blink_half_period_default = 25000000;  // 0.5 s

  // reset request pulse lengths in clocks
  localparam int unsigned cold_pulse_cycles  = 6;
  localparam int unsigned warm_pulse_cycles  = 2;
  localparam int unsigned debug_pulse_cycles = 32;
  localparam int unsigned pulse_cnt_width    = 6;  // holds up to 63

  typedef enum logic
  {
    pulse_idle,
    pulse_busy
  } pulse_state_e;

endpackage

//--- rtl/key_debounce.sv
`timescale 1ns/1ps

module key_debounce #(
  parameter int unsigned DEBOUNCE_CYCLES = glue_pkg::debounce_cycles_default
) (
  input  logic                          fpga_clk_50,
  input  logic                          hps_fpga_reset_n,
  input  logic [glue_pkg::num_keys-1:0] key_raw,
  output logic [glue_pkg::num_keys-1:0] key_clean
);

  localparam int unsigned cnt_w = $clog2(DEBOUNCE_CYCLES + 1);

  logic [glue_pkg::num_keys-1:0] key_meta;  // first sync stage
  logic [glue_pkg::num_keys-1:0] key_sync;  // second sync stage

  // ========================================
  // two-flop synchronizer
  // ========================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;  // released
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key_raw;
      key_sync <= key_meta;
    end
  end

  // ========================================
  // per-key stability counters
  // ========================================
  genvar i;
  generate
    for (i = 0; i < glue_pkg::num_keys; i++)
    begin : g_key
      logic [cnt_w-1:0] stable_cnt;  // clocks the input has disagreed

      always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
      begin
        if (!hps_fpga_reset_n)
        begin
          stable_cnt   <= '0;
          key_clean[i] <= 1'b1;
        end
        else if (key_sync[i] == key_clean[i])
          stable_cnt <= '0;  // bounce back, start over
        else if (stable_cnt == cnt_w'(DEBOUNCE_CYCLES - 1))
        begin
          stable_cnt   <= '0;
          key_clean[i] <= key_sync[i];  // held long enough, accept
        end
        else
          stable_cnt <= stable_cnt + 1'b1;
      end
    end
  endgenerate

endmodule

//--- rtl/reset_req_pulse.sv
`timescale 1ns/1ps

module reset_req_pulse #(
  parameter int unsigned PULSE_CYCLES = glue_pkg::cold_pulse_cycles
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req_level,
  output logic req_pulse_n
);

  logic req_meta;
  logic req_sync;
  logic req_prev;  // last synced value, for edge detect
  logic req_rise;

  glue_pkg::pulse_state_e state;
  logic [glue_pkg::pulse_cnt_width-1:0] pulse_cnt;  // clocks left after this one

  // ========================================
  // sync and rising edge
  // ========================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_meta <= 1'b0;
      req_sync <= 1'b0;
      req_prev <= 1'b0;
    end
    else
    begin
      req_meta <= req_level;
      req_sync <= req_meta;
      req_prev <= req_sync;
    end
  end

  assign req_rise = req_sync & ~req_prev;

  // pulse FSM, edges while busy are dropped
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state     <= glue_pkg::pulse_idle;
      pulse_cnt <= '0;
    end
    else if (state == glue_pkg::pulse_idle)
    begin
      if (req_rise)
      begin
        state     <= glue_pkg::pulse_busy;
        pulse_cnt <= glue_pkg::pulse_cnt_width'(PULSE_CYCLES - 1);
      end
    end
    else if (pulse_cnt == '0)
      state <= glue_pkg::pulse_idle;  // last low clock done
    else
      pulse_cnt <= pulse_cnt - 1'b1;
  end

  assign req_pulse_n = (state != glue_pkg::pulse_busy);  // low while busy

endmodule

//--- rtl/heartbeat_blinker.sv
`timescale 1ns/1ps

module heartbeat_blinker #(
  parameter int unsigned HALF_PERIOD = glue_pkg::blink_half_period_default
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led_level
);

  localparam int unsigned cnt_w = $clog2(HALF_PERIOD + 1);

  logic [cnt_w-1:0] div_cnt;  // free running divider

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      div_cnt   <= '0;
      led_level <= 1'b0;  // led off out of reset
    end
    else if (div_cnt == cnt_w'(HALF_PERIOD - 1))
    begin
      div_cnt   <= '0;
      led_level <= ~led_level;  // wrap, flip the led
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

endmodule

//--- rtl/fpga_glue_top.sv
`timescale 1ns/1ps

module fpga_glue_top #(
  parameter int unsigned DEBOUNCE_CYCLES   = glue_pkg::debounce_cycles_default,
  parameter int unsigned BLINK_HALF_PERIOD = glue_pkg::blink_half_period_default
) (
  input  logic                             fpga_clk_50,
  input  logic                             hps_fpga_reset_n,
  input  logic [glue_pkg::num_keys-1:0]    key,            // raw, active low
  input  logic [glue_pkg::num_sw-1:0]      sw,
  input  logic [glue_pkg::num_led_pio-1:0] led_pio,        // from processor
  input  logic [2:0]                       hps_reset_req,  // debug, warm, cold
  output logic [glue_pkg::num_ledr-1:0]    ledr,
  output logic [glue_pkg::num_keys-1:0]    debounced_keys, // to button port
  output logic [glue_pkg::stm_width-1:0]   stm_hw_events,
  output logic                             cold_reset_req_n,
  output logic                             warm_reset_req_n,
  output logic                             debug_reset_req_n
);

  logic heartbeat;  // ledr bit 0

  // ========================================
  // key debounce
  // ========================================
  key_debounce #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_raw          (key),
    .key_clean        (debounced_keys)
  );

  // ========================================
  // reset request pulses
  // ========================================
  reset_req_pulse #(
    .PULSE_CYCLES (glue_pkg::cold_pulse_cycles)
  ) u_cold_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req_level        (hps_reset_req[0]),
    .req_pulse_n      (cold_reset_req_n)
  );

  reset_req_pulse #(
    .PULSE_CYCLES (glue_pkg::warm_pulse_cycles)
  ) u_warm_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req_level        (hps_reset_req[1]),
    .req_pulse_n      (warm_reset_req_n)
  );

  reset_req_pulse #(
    .PULSE_CYCLES (glue_pkg::debug_pulse_cycles)
  ) u_debug_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req_level        (hps_reset_req[2]),
    .req_pulse_n      (debug_reset_req_n)
  );

  // heartbeat on the first led
  heartbeat_blinker #(
    .HALF_PERIOD (BLINK_HALF_PERIOD)
  ) u_heartbeat (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led_level        (heartbeat)
  );

  // ========================================
  // led and trace packing
  // ========================================
  assign ledr = {led_pio, heartbeat};  // processor leds on bits 9..1

  // top bits always zero
  assign stm_hw_events = {{glue_pkg::stm_pad_width{1'b0}}, sw, led_pio, debounced_keys};

endmodule

//--- dv/tb_fpga_glue_top.sv
`timescale 1ns/1ps

module tb_fpga_glue_top;

  // ========================================
  // shrunk timing for simulation
  // ========================================
  localparam int tb_debounce   = 16;
  localparam int tb_blink_half = 20;
  localparam int pad_w = glue_pkg::stm_width - glue_pkg::num_sw - glue_pkg::num_led_pio
                         - glue_pkg::num_keys;

  // rough run length: reset, random, 3 key runs, 4 pulses, blink toggles
  localparam int tb_test_cycles = 1500;
  localparam int timeout_cycles = 2 * tb_test_cycles;

  logic                             fpga_clk_50;
  logic                             hps_fpga_reset_n;
  logic [glue_pkg::num_keys-1:0]    key;
  logic [glue_pkg::num_sw-1:0]      sw;
  logic [glue_pkg::num_led_pio-1:0] led_pio;
  logic [2:0]                       hps_reset_req;  // debug, warm, cold
  logic [glue_pkg::num_ledr-1:0]    ledr;
  logic [glue_pkg::num_keys-1:0]    debounced_keys;
  logic [glue_pkg::stm_width-1:0]   stm_hw_events;
  logic                             cold_reset_req_n;
  logic                             warm_reset_req_n;
  logic                             debug_reset_req_n;

  logic [glue_pkg::stm_width-1:0] stm_expected;
  int seed;
  int cycle_cnt;

  fpga_glue_top #(
    .DEBOUNCE_CYCLES   (tb_debounce),
    .BLINK_HALF_PERIOD (tb_blink_half)
  ) u_dut (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .led_pio           (led_pio),
    .hps_reset_req     (hps_reset_req),
    .ledr              (ledr),
    .debounced_keys    (debounced_keys),
    .stm_hw_events     (stm_hw_events),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n)
  );

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #2 fpga_clk_50 = ~fpga_clk_50;  // 4 ns period
  end

  // ========================================
  // error reporting
  // ========================================
  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "run aborted");
  endtask

  always @(posedge fpga_clk_50)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
      report_failure($sformatf("timeout: tests still running after %0d cycles", cycle_cnt));
  end

  // trace word and leds follow inputs in the same cycle
  assign stm_expected = {{pad_w{1'b0}}, sw, led_pio, debounced_keys};

  a_stm_pack : assert property (@(negedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    stm_hw_events == stm_expected)
    else report_value("stm_pack", 32'(stm_expected), 32'(stm_hw_events));

  a_ledr_pio : assert property (@(negedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    ledr[glue_pkg::num_ledr-1:1] == led_pio)
    else report_value("ledr_pio", 32'(led_pio), 32'(ledr[glue_pkg::num_ledr-1:1]));

  // ========================================
  // helpers
  // ========================================
  task automatic next_cycle();
    @(posedge fpga_clk_50);
    #1;  // drive and sample just after the edge
  endtask

  function automatic logic req_out(input int idx);
    case (idx)
      0:       return cold_reset_req_n;
      1:       return warm_reset_req_n;
      default: return debug_reset_req_n;
    endcase
  endfunction

  task automatic check_reset_state();
    assert (debounced_keys == '1)
      else report_value("reset_keys", 32'hF, 32'(debounced_keys));
    assert ({debug_reset_req_n, warm_reset_req_n, cold_reset_req_n} == 3'b111)
      else report_value("reset_req_n", 32'h7,
                        32'({debug_reset_req_n, warm_reset_req_n, cold_reset_req_n}));
    assert (ledr[0] == 1'b0)
      else report_value("reset_heartbeat", 32'h0, 32'(ledr[0]));
  endtask

  task automatic drive_random_io(input int count);
    int n;
    int rnd;
    for (n = 0; n < count; n++)
    begin
      rnd     = $random(seed);
      sw      = rnd[glue_pkg::num_sw-1:0];
      rnd     = $random(seed);
      led_pio = rnd[glue_pkg::num_led_pio-1:0];
      next_cycle();  // negedge assertions check the packing
    end
  endtask

  // press one key for hold clocks, then release and watch it settle
  task automatic press_key(input int idx, input int hold, input string name);
    int k;
    int since;
    logic exp_bit;
    logic check;
    logic [glue_pkg::num_keys-1:0] exp_keys;
    key[idx] = 1'b0;
    for (k = 1; k <= hold + tb_debounce + 8; k++)
    begin
      next_cycle();
      check   = 1'b1;
      exp_bit = 1'b1;  // glitch never accepted
      if (hold >= tb_debounce)
      begin
        since = (k <= hold) ? k : k - hold;
        // output may move at debounce+2 or debounce+3
        check   = (since < tb_debounce + 2) || (since >= tb_debounce + 4);
        exp_bit = (k <= hold) ? (since < tb_debounce + 2) : (since >= tb_debounce + 4);
      end
      exp_keys      = '1;
      exp_keys[idx] = exp_bit;
      if (check)
        assert (debounced_keys == exp_keys)
          else report_value(name, 32'(exp_keys), 32'(debounced_keys));
      if (k == hold)
        key[idx] = 1'b1;  // release
    end
  endtask

  // one rising request edge, optional retrigger while busy
  task automatic check_req_pulse(input int idx, input int width, input int retrig,
                                 input string name);
    int k;
    int low_total;
    int runs;
    int first_low;
    logic prev_n;
    logic cur_n;
    low_total = 0;
    runs      = 0;
    first_low = 0;
    prev_n    = 1'b1;
    hps_reset_req[idx] = 1'b1;
    for (k = 1; k <= width + 16; k++)
    begin
      next_cycle();
      cur_n = req_out(idx);
      if (!cur_n && prev_n)
      begin
        runs++;
        if (runs == 1)
          first_low = k;
      end
      if (!cur_n)
        low_total++;
      if (retrig > 0 && low_total == retrig && !cur_n)
        hps_reset_req[idx] = 1'b0;
      if (retrig > 0 && low_total == retrig + 3 && !cur_n)
        hps_reset_req[idx] = 1'b1;  // new edge lands mid pulse
      prev_n = cur_n;
    end
    assert (runs == 1)
      else report_value({name, "_runs"}, 32'd1, 32'(runs));
    assert (first_low >= 1 && first_low <= 3)
      else report_value({name, "_start"}, 32'd3, 32'(first_low));
    assert (low_total == width)
      else report_value({name, "_width"}, 32'(width), 32'(low_total));
    hps_reset_req[idx] = 1'b0;
    repeat (4) next_cycle();  // let the synchronizer drain
  endtask

  task automatic check_heartbeat(input int toggles);
    int t;
    int gap;
    logic last;
    last = ledr[0];
    while (ledr[0] == last)
      next_cycle();  // align to a toggle
    for (t = 0; t < toggles; t++)
    begin
      last = ledr[0];
      gap  = 0;
      while (ledr[0] == last)
      begin
        next_cycle();
        gap++;
      end
      assert (gap == tb_blink_half)
        else report_value("heartbeat_gap", 32'(tb_blink_half), 32'(gap));
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial
  begin
    seed             = 94081;
    hps_fpga_reset_n = 1'b0;
    key              = '1;  // released
    sw               = '0;
    led_pio          = '0;
    hps_reset_req    = '0;
    repeat (3) @(posedge fpga_clk_50);
    #1;
    hps_fpga_reset_n = 1'b1;

    check_reset_state();
    drive_random_io(20);

    press_key(0, 8, "key_glitch");
    press_key(1, 40, "key_hold");
    press_key(3, 40, "key_hold_hi");

    check_req_pulse(0, glue_pkg::cold_pulse_cycles, 0, "cold_pulse");
    check_req_pulse(1, glue_pkg::warm_pulse_cycles, 0, "warm_pulse");
    check_req_pulse(2, glue_pkg::debug_pulse_cycles, 0, "debug_pulse");
    check_req_pulse(2, glue_pkg::debug_pulse_cycles, 10, "debug_retrig");

    check_heartbeat(5);

    $display("All checks passed");
    $finish;
  end

endmodule

//--- tb.f
rtl/glue_pkg.sv
rtl/key_debounce.sv
rtl/reset_req_pulse.sv
rtl/heartbeat_blinker.sv
rtl/fpga_glue_top.sv
dv/tb_fpga_glue_top.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert \
    --top-module tb_fpga_glue_top \
    --Mdir obj_dir \
    -f tb.f; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_fpga_glue_top 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if grep -q "All checks passed" <<< "$sim_out"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
